//--- spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pin and frame sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int SPI_BITS    = 3;
    localparam int FRAME_BITS  = 36;
    localparam int FRAME_BEATS = FRAME_BITS / SPI_BITS;
    localparam int REPLY_BITS  = 32;
    localparam int ID_BITS     = 4;

    // Field positions inside a received frame
    localparam int ID_LSB   = 0;
    localparam int ID_MSB   = ID_LSB + ID_BITS - 1;
    localparam int MODE_LSB = 4;
    localparam int MODE_MSB = 7;
    localparam int ADDR_LSB = 4;
    localparam int ADDR_MSB = 11;
    localparam int DATA_LSB = 12;
    localparam int DATA_MSB = 19;
    localparam int CODE_LSB = 4;
    localparam int CODE_MSB = 35;

    typedef enum logic [ID_BITS-1:0] {
        DEV_MODE      = 4'd0,
        DEV_TABLE     = 4'd1,
        DEV_CODE      = 4'd2,
        DEV_PHASE_CLR = 4'd3
    } dev_id_t;

endpackage

`default_nettype wire

//--- dds_pkg.sv
`default_nettype none

package dds_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Generator datapath widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int PHASE_BITS      = 32;
    localparam int TABLE_ADDR_BITS = 8;
    localparam int TABLE_DATA_BITS = 8;
    localparam int TABLE_DEPTH     = 1 << TABLE_ADDR_BITS;

    // Module pins
    localparam int IO_BITS = 10;

    localparam int MODE_BITS = 4;

    // Output mode of the pin group
    typedef enum logic [MODE_BITS-1:0] {
        MODE_NONE = 4'd0,
        MODE_DDS  = 4'd1
    } mode_t;

endpackage

`default_nettype wire

//--- dds_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface dds_cfg_if;

    dds_pkg::mode_t                       mode;
    logic                                 table_we;
    logic [dds_pkg::TABLE_ADDR_BITS-1:0]  table_addr;
    logic [dds_pkg::TABLE_DATA_BITS-1:0]  table_data;
    logic [dds_pkg::PHASE_BITS-1:0]       code;
    logic                                 phase_clr;

    // Command side drives everything
    modport ctrl (
        output mode, table_we, table_addr, table_data, code, phase_clr
    );

    modport accum (
        input code, phase_clr
    );

    // Waveform memory and pin stage
    modport tbl (
        input mode, table_we, table_addr, table_data
    );

endinterface

`default_nettype wire

//--- spi_frame_rx.sv
`timescale 1ns/10ps
`default_nettype none

module spi_frame_rx (
    input  wire                                  clk,
    input  wire                                  nreset,
    input  wire                                  sclk,
    input  wire                                  sncs,
    input  wire  [spi_cmd_pkg::SPI_BITS-1:0]     sdi,
    input  wire  [spi_cmd_pkg::REPLY_BITS-1:0]   reply_word,
    output logic [spi_cmd_pkg::SPI_BITS-1:0]     sdo,
    output logic                                 frame_valid,
    output logic [spi_cmd_pkg::FRAME_BITS-1:0]   frame_data
);

    logic [1:0]                            sclk_sync;
    logic [1:0]                            sncs_sync;
    logic [spi_cmd_pkg::SPI_BITS-1:0]      sdi_meta;
    logic [spi_cmd_pkg::SPI_BITS-1:0]      sdi_s;
    logic                                  sclk_d;
    logic                                  sncs_d;
    logic                                  sclk_rise;
    logic                                  sncs_rise;
    logic                                  sncs_fall;
    logic [spi_cmd_pkg::FRAME_BITS-1:0]    frame_q;
    logic [spi_cmd_pkg::REPLY_BITS-1:0]    reply_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pin synchronizers and edge detect
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!nreset) begin
            sclk_sync   <= 2'b00;
            sncs_sync   <= 2'b11;
            sclk_d      <= 1'b0;
            sncs_d      <= 1'b1;
            frame_valid <= 1'b0;
        end else begin
            sclk_sync   <= {sclk_sync[0], sclk};
            sncs_sync   <= {sncs_sync[0], sncs};
            sclk_d      <= sclk_sync[1];
            sncs_d      <= sncs_sync[1];
            frame_valid <= sncs_rise;
        end
    end

    // Data lanes, same depth as sclk so they stay aligned
    always_ff @(posedge clk) begin
        sdi_meta <= sdi;
        sdi_s    <= sdi_meta;
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_d;
    assign sncs_rise = sncs_sync[1] & ~sncs_d;
    assign sncs_fall = ~sncs_sync[1] & sncs_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame and reply shifters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (sclk_rise && !sncs_sync[1]) begin
            frame_q <= {frame_q[spi_cmd_pkg::FRAME_BITS-spi_cmd_pkg::SPI_BITS-1:0], sdi_s};
        end
    end

    always_ff @(posedge clk) begin
        if (sncs_fall) begin
            reply_q <= reply_word;
        end else if (sclk_rise && !sncs_sync[1]) begin
            reply_q <= {reply_q[spi_cmd_pkg::REPLY_BITS-spi_cmd_pkg::SPI_BITS-1:0],
                        {spi_cmd_pkg::SPI_BITS{1'b0}}};
        end
    end

    assign frame_data = frame_q;

    // MSB lane group first, idle high
    assign sdo = sncs_sync[1] ? {spi_cmd_pkg::SPI_BITS{1'b1}}
                              : reply_q[spi_cmd_pkg::REPLY_BITS-1 -: spi_cmd_pkg::SPI_BITS];

    // One decode per sncs rise
    frame_valid_single_a : assert property (
        @(posedge clk) disable iff (!nreset)
        frame_valid |=> !frame_valid
    );

endmodule

`default_nettype wire

//--- cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_ctrl (
    input  wire                                  clk,
    input  wire                                  nreset,
    input  wire                                  frame_valid,
    input  wire  [spi_cmd_pkg::FRAME_BITS-1:0]   frame_data,
    output logic [spi_cmd_pkg::REPLY_BITS-1:0]   reply_word,
    dds_cfg_if.ctrl                              cfg
);

    typedef enum logic [2:0] {
        IDLE,
        DECODE,
        SET_MODE,
        WRITE_TABLE,
        LOAD_CODE,
        CLEAR_PHASE
    } state_t;

    state_t                          state;
    spi_cmd_pkg::dev_id_t            frame_id;
    dds_pkg::mode_t                  mode_q;
    logic [dds_pkg::PHASE_BITS-1:0]  code_q;

    assign frame_id = spi_cmd_pkg::dev_id_t'(
        frame_data[spi_cmd_pkg::ID_MSB:spi_cmd_pkg::ID_LSB]);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Command FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!nreset) begin
            state  <= IDLE;
            mode_q <= dds_pkg::MODE_NONE;
            code_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame_valid) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    // Mode and code become visible in the action state
                    case (frame_id)
                        spi_cmd_pkg::DEV_MODE: begin
                            state  <= SET_MODE;
                            mode_q <= dds_pkg::mode_t'(
                                frame_data[spi_cmd_pkg::MODE_MSB:spi_cmd_pkg::MODE_LSB]);
                        end
                        spi_cmd_pkg::DEV_TABLE: state <= WRITE_TABLE;
                        spi_cmd_pkg::DEV_CODE: begin
                            state  <= LOAD_CODE;
                            code_q <= frame_data[spi_cmd_pkg::CODE_MSB:spi_cmd_pkg::CODE_LSB];
                        end
                        spi_cmd_pkg::DEV_PHASE_CLR: state <= CLEAR_PHASE;
                        default: state <= IDLE;
                    endcase
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign cfg.mode       = mode_q;
    assign cfg.code       = code_q;
    assign cfg.table_we   = (state == WRITE_TABLE);
    assign cfg.phase_clr  = (state == CLEAR_PHASE);
    assign cfg.table_addr = frame_data[spi_cmd_pkg::ADDR_MSB:spi_cmd_pkg::ADDR_LSB];
    assign cfg.table_data = frame_data[spi_cmd_pkg::DATA_MSB:spi_cmd_pkg::DATA_LSB];

    assign reply_word = code_q;

    strobes_exclusive_a : assert property (
        @(posedge clk) disable iff (!nreset)
        !(cfg.table_we && cfg.phase_clr)
    );

    // Frames are far apart, so decode is always done when the next one lands
    frame_while_idle_a : assert property (
        @(posedge clk) disable iff (!nreset)
        frame_valid |-> (state == IDLE)
    );

endmodule

`default_nettype wire

//--- phase_accum.sv
`timescale 1ns/10ps
`default_nettype none

module phase_accum (
    input  wire                                  clk,
    input  wire                                  nreset,
    dds_cfg_if.accum                             cfg,
    output logic [dds_pkg::TABLE_ADDR_BITS-1:0]  table_index
);

    logic [dds_pkg::PHASE_BITS-1:0] phase_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Phase accumulator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!nreset) begin
            phase_q <= '0;
        end else if (cfg.phase_clr) begin
            phase_q <= '0;
        end else begin
            // Wraps freely at 2^32
            phase_q <= phase_q + cfg.code;
        end
    end

    // Top bits index the waveform table
    assign table_index = phase_q[dds_pkg::PHASE_BITS-1 -: dds_pkg::TABLE_ADDR_BITS];

    phase_clr_zero_a : assert property (
        @(posedge clk) disable iff (!nreset)
        cfg.phase_clr |=> (phase_q == '0)
    );

endmodule

`default_nettype wire

//--- wave_table.sv
`timescale 1ns/10ps
`default_nettype none

module wave_table (
    input  wire                                  clk,
    input  wire                                  nreset,
    input  wire  [dds_pkg::TABLE_ADDR_BITS-1:0]  table_index,
    dds_cfg_if.tbl                               cfg,
    output logic [dds_pkg::IO_BITS-1:0]          module_out,
    output logic [dds_pkg::IO_BITS-1:0]          module_oe
);

    logic [dds_pkg::TABLE_DATA_BITS-1:0] mem [dds_pkg::TABLE_DEPTH];
    logic [dds_pkg::TABLE_DATA_BITS-1:0] rd_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Waveform memory
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (cfg.table_we) begin
            mem[cfg.table_addr] <= cfg.table_data;
        end
    end

    // Registered lookup at the phase index
    always_ff @(posedge clk) begin
        rd_q <= mem[table_index];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pin drive
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!nreset) begin
            module_out <= '0;
            module_oe  <= '0;
        end else begin
            case (cfg.mode)
                dds_pkg::MODE_DDS: begin
                    // Byte on the low pins, upper pins driven low
                    module_out <= {{(dds_pkg::IO_BITS-dds_pkg::TABLE_DATA_BITS){1'b0}}, rd_q};
                    module_oe  <= '1;
                end
                default: begin
                    module_out <= '0;
                    module_oe  <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- device_handler.sv
`timescale 1ns/10ps
`default_nettype none

module device_handler (
    input  wire                               clk,
    input  wire                               nreset,
    input  wire  [spi_cmd_pkg::SPI_BITS-1:0]  sdi,
    output wire  [spi_cmd_pkg::SPI_BITS-1:0]  sdo,
    input  wire                               sclk,
    input  wire                               sncs,
    input  wire  [dds_pkg::IO_BITS-1:0]       module_in,
    output wire  [dds_pkg::IO_BITS-1:0]       module_out,
    output wire  [dds_pkg::IO_BITS-1:0]       module_oe
);

    wire                                  frame_valid;
    wire [spi_cmd_pkg::FRAME_BITS-1:0]    frame_data;
    wire [spi_cmd_pkg::REPLY_BITS-1:0]    reply_word;
    wire [dds_pkg::TABLE_ADDR_BITS-1:0]   table_index;

    dds_cfg_if cfg_if ();

    spi_frame_rx spi_frame_rx_i (
        .clk         (clk),
        .nreset      (nreset),
        .sclk        (sclk),
        .sncs        (sncs),
        .sdi         (sdi),
        .reply_word  (reply_word),
        .sdo         (sdo),
        .frame_valid (frame_valid),
        .frame_data  (frame_data)
    );

    cmd_ctrl cmd_ctrl_i (
        .clk         (clk),
        .nreset      (nreset),
        .frame_valid (frame_valid),
        .frame_data  (frame_data),
        .reply_word  (reply_word),
        .cfg         (cfg_if.ctrl)
    );

    phase_accum phase_accum_i (
        .clk         (clk),
        .nreset      (nreset),
        .cfg         (cfg_if.accum),
        .table_index (table_index)
    );

    wave_table wave_table_i (
        .clk         (clk),
        .nreset      (nreset),
        .table_index (table_index),
        .cfg         (cfg_if.tbl),
        .module_out  (module_out),
        .module_oe   (module_oe)
    );

endmodule

`default_nettype wire

//--- tb_device_handler.sv
`timescale 1ns/10ps
`default_nettype none

module tb_device_handler;

    localparam int CLK_PERIOD   = 100;
    localparam int SCLK_HALF    = 8;
    localparam int SETTLE       = 8;
    localparam int STEP_CYCLES  = 40;
    localparam int FRAME_CYCLES = 1 + SCLK_HALF + SETTLE
                                  + spi_cmd_pkg::FRAME_BEATS * (2 * SCLK_HALF + 1);
    localparam int TOTAL_FRAMES = dds_pkg::TABLE_DEPTH + 20;
    localparam int WATCHDOG_CYCLES = TOTAL_FRAMES * FRAME_CYCLES + 1000;

    logic                                 clk;
    logic                                 nreset;
    logic                                 sclk;
    logic                                 sncs;
    logic [spi_cmd_pkg::SPI_BITS-1:0]     sdi;
    wire  [spi_cmd_pkg::SPI_BITS-1:0]     sdo;
    logic [dds_pkg::IO_BITS-1:0]          module_in;
    wire  [dds_pkg::IO_BITS-1:0]          module_out;
    wire  [dds_pkg::IO_BITS-1:0]          module_oe;

    logic [dds_pkg::TABLE_DATA_BITS-1:0]  wave_bytes [dds_pkg::TABLE_DEPTH];
    logic [31:0]                          rng;
    logic [spi_cmd_pkg::REPLY_BITS-1:0]   code_model;
    int                                   value_errors;
    int                                   other_errors;

    device_handler dut_i (
        .clk        (clk),
        .nreset     (nreset),
        .sdi        (sdi),
        .sdo        (sdo),
        .sclk       (sclk),
        .sncs       (sncs),
        .module_in  (module_in),
        .module_out (module_out),
        .module_oe  (module_oe)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Payload lands on frame bits 35..4 and id on 3..0
    function automatic logic [spi_cmd_pkg::FRAME_BITS-1:0] make_frame(
        input logic [spi_cmd_pkg::ID_BITS-1:0] id,
        input logic [31:0]                     payload
    );
        return {payload, id};
    endfunction

    function automatic logic [31:0] mode_payload(input dds_pkg::mode_t mode);
        logic [31:0] p;
        p = '0;
        p[dds_pkg::MODE_BITS-1:0] = mode;
        return p;
    endfunction

    function automatic logic [dds_pkg::IO_BITS-1:0] pin_value(
        input logic [dds_pkg::TABLE_DATA_BITS-1:0] b
    );
        logic [dds_pkg::IO_BITS-1:0] w;
        w = '0;
        w[dds_pkg::TABLE_DATA_BITS-1:0] = b;
        return w;
    endfunction

    task automatic check_out(input logic [dds_pkg::IO_BITS-1:0] actual,
                             input logic [dds_pkg::IO_BITS-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %0t module_out expected %h got %h", $time, expected, actual);
        end
    endtask

    task automatic check_oe(input logic [dds_pkg::IO_BITS-1:0] actual,
                            input logic [dds_pkg::IO_BITS-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %0t module_oe expected %h got %h", $time, expected, actual);
        end
    endtask

    task automatic check_reply(input logic [spi_cmd_pkg::REPLY_BITS-1:0] actual,
                               input logic [spi_cmd_pkg::REPLY_BITS-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %0t reply_word expected %h got %h", $time, expected, actual);
        end
    endtask

    task automatic check_lanes(input logic [spi_cmd_pkg::SPI_BITS-1:0] actual,
                               input logic [spi_cmd_pkg::SPI_BITS-1:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL %0t sdo expected %b got %b", $time, expected, actual);
        end
    endtask

    // MSB lane group first with sdo sampled just before each sclk rise
    task automatic spi_frame(input  logic [spi_cmd_pkg::FRAME_BITS-1:0] frame,
                             output logic [spi_cmd_pkg::REPLY_BITS-1:0] reply);
        logic [spi_cmd_pkg::FRAME_BITS-1:0] rx;
        rx = '0;
        @(posedge clk);
        sncs <= 1'b0;
        sdi  <= frame[spi_cmd_pkg::FRAME_BITS-1 -: spi_cmd_pkg::SPI_BITS];
        repeat (SCLK_HALF) @(posedge clk);
        for (int beat = 0; beat < spi_cmd_pkg::FRAME_BEATS; beat++) begin
            @(negedge clk);
            rx = {rx[spi_cmd_pkg::FRAME_BITS-spi_cmd_pkg::SPI_BITS-1:0], sdo};
            @(posedge clk);
            sclk <= 1'b1;
            repeat (SCLK_HALF) @(posedge clk);
            sclk <= 1'b0;
            if (beat < spi_cmd_pkg::FRAME_BEATS - 1) begin
                sdi <= frame[spi_cmd_pkg::FRAME_BITS-1-spi_cmd_pkg::SPI_BITS*(beat+1)
                             -: spi_cmd_pkg::SPI_BITS];
            end
            repeat (SCLK_HALF) @(posedge clk);
        end
        sncs <= 1'b1;
        repeat (SETTLE) @(posedge clk);
        reply = rx[spi_cmd_pkg::FRAME_BITS-1 -: spi_cmd_pkg::REPLY_BITS];
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic after_reset();
        @(negedge clk);
        check_out(module_out, '0);
        check_oe(module_oe, '0);
        check_lanes(sdo, '1);
    endtask

    task automatic constant_output();
        logic [31:0] reply;
        logic [7:0]  addr;
        for (int i = 0; i < dds_pkg::TABLE_DEPTH; i++) begin
            rng = xorshift32(rng);
            wave_bytes[i] = rng[7:0];
            addr = i;
            spi_frame(make_frame(spi_cmd_pkg::DEV_TABLE, {16'h0, wave_bytes[i], addr}), reply);
        end
        code_model = '0;
        spi_frame(make_frame(spi_cmd_pkg::DEV_CODE, code_model), reply);
        spi_frame(make_frame(spi_cmd_pkg::DEV_PHASE_CLR, '0), reply);
        spi_frame(make_frame(spi_cmd_pkg::DEV_MODE, mode_payload(dds_pkg::MODE_DDS)), reply);
        @(negedge clk);
        check_out(module_out, pin_value(wave_bytes[0]));
        check_oe(module_oe, '1);
    endtask

    task automatic stepping_output();
        logic [31:0] reply;
        int          base;
        spi_frame(make_frame(spi_cmd_pkg::DEV_CODE, 32'h0100_0000), reply);
        check_reply(reply, code_model);
        code_model = 32'h0100_0000;
        spi_frame(make_frame(spi_cmd_pkg::DEV_PHASE_CLR, '0), reply);
        check_reply(reply, code_model);
        @(negedge clk);
        base = -1;
        for (int i = dds_pkg::TABLE_DEPTH - 1; i >= 0; i--) begin
            if (pin_value(wave_bytes[i]) === module_out) begin
                base = i;
            end
        end
        if (base < 0) begin
            other_errors++;
            $display("Stepping output %h matches no table entry", module_out);
        end else begin
            for (int n = 1; n <= STEP_CYCLES; n++) begin
                @(negedge clk);
                check_out(module_out, pin_value(wave_bytes[(base + n) % dds_pkg::TABLE_DEPTH]));
            end
        end
        check_oe(module_oe, '1);
    endtask

    task automatic readback_word();
        logic [31:0] reply;
        rng = xorshift32(rng);
        spi_frame(make_frame(spi_cmd_pkg::DEV_CODE, rng), reply);
        code_model = rng;
        spi_frame(make_frame(spi_cmd_pkg::DEV_MODE, mode_payload(dds_pkg::MODE_DDS)), reply);
        check_reply(reply, code_model);
    endtask

    task automatic none_and_unknown();
        logic [31:0] reply;
        spi_frame(make_frame(spi_cmd_pkg::DEV_MODE, mode_payload(dds_pkg::MODE_NONE)), reply);
        check_reply(reply, code_model);
        @(negedge clk);
        check_out(module_out, '0);
        check_oe(module_oe, '0);
        // Id 9 with the DDS mode in its mode field must leave everything alone
        rng = xorshift32(rng);
        spi_frame(make_frame(4'd9, {rng[31:dds_pkg::MODE_BITS], dds_pkg::MODE_DDS}), reply);
        check_reply(reply, code_model);
        @(negedge clk);
        check_out(module_out, '0);
        check_oe(module_oe, '0);
        check_lanes(sdo, '1);
        spi_frame(make_frame(4'd9, '0), reply);
        check_reply(reply, code_model);
    endtask

    initial begin
        nreset       = 1'b0;
        sclk         = 1'b0;
        sncs         = 1'b1;
        sdi          = '0;
        module_in    = '0;
        rng          = 32'd70;
        code_model   = '0;
        value_errors = 0;
        other_errors = 0;
        repeat (5) @(posedge clk);
        nreset <= 1'b1;
        @(posedge clk);
        after_reset();
        constant_output();
        stepping_output();
        readback_word();
        none_and_unknown();
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- device_handler.f
spi_cmd_pkg.sv
dds_pkg.sv
dds_cfg_if.sv
spi_frame_rx.sv
cmd_ctrl.sv
phase_accum.sv
wave_table.sv
device_handler.sv
tb_device_handler.sv

//--- Bender.yml
package:
  name: device_handler

sources:
  - spi_cmd_pkg.sv
  - dds_pkg.sv
  - dds_cfg_if.sv
  - spi_frame_rx.sv
  - cmd_ctrl.sv
  - phase_accum.sv
  - wave_table.sv
  - device_handler.sv
  - target: test
    files:
      - tb_device_handler.sv
